// File: list.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_core.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# verilator build and run of the rv_core testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_rv_core -o tb_rv_core -f list.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: testbench/tb_rv_core.sv
// --------------------------------------------------------------------------
// testbench for rv_core: program table, instruction memory, pc and store checks
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;
  import rv_isa_pkg::*;

  localparam logic [31:0] NOP     = 32'h0000_0013;
  localparam logic [31:0] ECALL   = 32'h0000_0073;
  localparam logic [31:0] ST_BASE = 32'h0000_0100;

  // one program word with the store and next pc it must produce
  typedef struct packed {
    logic [31:0] insn;
    logic        st;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] next;
  } entry_t;

  logic        clk, rst;
  logic [31:0] i_insn, o_pc, o_dmem_addr, o_dmem_wdata;
  logic [3:0]  o_dmem_be;
  logic        o_halt;

  entry_t      prog [$];
  logic [31:0] imem [0:255];
  logic [31:0] lcg_state;
  logic [31:0] exp_pc = `RV_RESET_PC;
  int          prog_len = 0;
  int          store_slot = 0;
  int          halt_cycles = 0;
  int          err_pc = 0;
  int          err_store = 0;
  int          err_halt = 0;
  logic        timed_out;

  rv_core dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (i_insn),
    .o_pc         (o_pc),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_be    (o_dmem_be),
    .o_halt       (o_halt)
  );

  always #5 clk = ~clk;

  // instruction memory answers in the same cycle
  always_comb begin
    i_insn = NOP;
    if (!rst && (o_pc - `RV_RESET_PC) < 32'(4 * prog_len)) begin
      i_insn = imem[8'((o_pc - `RV_RESET_PC) >> 2)];
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // reference results from the rv32i rules
  function automatic logic [31:0] model_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    logic signed [31:0] sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? sra : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic model_branch(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] cur_pc();
    return `RV_RESET_PC + 32'(4 * prog.size());
  endfunction

  task automatic put(logic [31:0] insn, logic st, logic [31:0] addr, logic [31:0] data,
                     logic [31:0] next);
    prog.push_back(entry_t'{insn, st, addr, data, next});
  endtask

  task automatic put_plain(logic [31:0] insn);
    put(insn, 1'b0, '0, '0, cur_pc() + 32'd4);
  endtask

  // addi sign-extends the low part, so round the upper part
  task automatic load_const(logic [4:0] rd, logic [31:0] val);
    logic [31:0] hi;
    hi = val + 32'h800;
    put_plain({hi[31:12], rd, OP_LUI});
    put_plain(enc_i(val[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic store_expect(logic [4:0] rs2, logic [31:0] value);
    logic [11:0] off;
    off = 12'(4 * store_slot);
    put(enc_s(off, rs2, 5'd1), 1'b1, ST_BASE + 32'(off), value, cur_pc() + 32'd4);
    store_slot++;
  endtask

  task automatic build_program();
    logic [31:0] a, b, imm, pc0;
    logic [2:0]  f3;
    logic        alt, taken;
    // x1 is the store base
    put_plain(enc_i(ST_BASE[11:0], 5'd0, 3'b000, 5'd1, OP_IMM));
    for (int k = 0; k < 9; k++) begin
      f3  = (k == 8) ? 3'b101 : 3'(k);
      alt = (k == 8);
      a   = next_rand();
      if (alt) a[31] = 1'b1;
      imm = next_rand();
      if (f3[1:0] == 2'b01) begin
        imm = {27'b0, imm[4:0]};
        imm[10] = alt;
      end else begin
        imm = {{20{imm[11]}}, imm[11:0]};
      end
      load_const(5'd2, a);
      put_plain(enc_i(imm[11:0], 5'd2, f3, 5'd4, OP_IMM));
      store_expect(5'd4, model_op(f3, alt, a, imm));
    end
    // sub and sra come last
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
      alt = (k >= 8);
      a   = next_rand();
      b   = next_rand();
      if (k == 9) a[31] = 1'b1;
      load_const(5'd2, a);
      load_const(5'd3, b);
      put_plain(enc_r(alt ? F7_ALT : F7_BASE, 5'd3, 5'd2, f3, 5'd4));
      store_expect(5'd4, model_op(f3, alt, a, b));
    end
    put_plain(enc_r(F7_BASE, 5'd3, 5'd2, 3'b000, 5'd0));
    store_expect(5'd0, 32'd0);
    // equal pairs on even k and opposite signs on odd k give six taken
    for (int k = 0; k < 12; k++) begin
      f3 = (k < 4) ? 3'(k / 2) : 3'(k / 2 + 2);
      a  = next_rand();
      b  = (k % 2 == 0) ? a : next_rand();
      // signed and unsigned order disagree for these pairs
      if (k % 2 == 1) begin
        a[31] = (k < 8);
        b[31] = (k >= 8);
      end
      load_const(5'd2, a);
      load_const(5'd3, b);
      taken = model_branch(f3, a, b);
      pc0   = cur_pc();
      put(enc_b(13'd8, 5'd3, 5'd2, f3), 1'b0, '0, '0, taken ? pc0 + 32'd8 : pc0 + 32'd4);
      store_expect(5'd2, a);
    end
    pc0 = cur_pc();
    put(enc_j(21'd8, 5'd5), 1'b0, '0, '0, pc0 + 32'd8);
    put_plain(enc_i(12'd1, 5'd0, 3'b000, 5'd5, OP_IMM));
    store_expect(5'd5, pc0 + 32'd4);
    // jalr target is odd before bit 0 is cleared
    pc0 = cur_pc();
    load_const(5'd6, pc0 + 32'd16);
    put(enc_i(12'd1, 5'd6, 3'b000, 5'd7, OP_JALR), 1'b0, '0, '0, pc0 + 32'd16);
    put_plain(enc_i(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM));
    store_expect(5'd7, pc0 + 32'd12);
    imm = next_rand();
    put_plain({imm[31:12], 5'd8, OP_LUI});
    store_expect(5'd8, {imm[31:12], 12'b0});
    pc0 = cur_pc();
    put_plain({imm[31:12], 5'd9, OP_AUIPC});
    store_expect(5'd9, pc0 + {imm[31:12], 12'b0});
    // misaligned sw stores nothing
    put_plain(enc_s(12'd2, 5'd2, 5'd1));
    pc0 = cur_pc();
    put(ECALL, 1'b0, '0, '0, pc0);
  endtask

  always @(posedge clk) begin
    entry_t e;
    int     idx;
    if (rst) begin
      exp_pc = `RV_RESET_PC;
    end else if (o_pc !== exp_pc) begin
      err_pc++;
      $display("Error %0t: pc %h, expected %h", $time, o_pc, exp_pc);
    end else begin
      idx = int'((o_pc - `RV_RESET_PC) >> 2);
      e   = prog[idx];
      if (o_dmem_be !== {4{e.st}} || o_dmem_addr !== e.addr || o_dmem_wdata !== e.data) begin
        err_store++;
        $display("Error %0t: pc %h store be %h addr %h data %h, expected be %h addr %h data %h",
                 $time, o_pc, o_dmem_be, o_dmem_addr, o_dmem_wdata, {4{e.st}}, e.addr, e.data);
      end
      if (o_halt !== (e.insn == ECALL)) begin
        err_halt++;
        $display("Error %0t: pc %h halt %b", $time, o_pc, o_halt);
      end
      if (o_halt) halt_cycles++;
      exp_pc = e.next;
    end
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    timed_out = 1'b0;
    lcg_state = 32'd14066;
    build_program();
    prog_len = prog.size();
    for (int i = 0; i < prog_len; i++) begin
      imem[8'(i)] = prog[i].insn;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    fork
      wait (halt_cycles > 10);
      begin
        repeat (prog_len * 4 + 50) @(posedge clk);
        timed_out = 1'b1;
      end
    join_any
    if (timed_out) $display("halt was never seen within %0d cycles", prog_len * 4 + 50);
    $display("errors: pc %0d, store %0d, halt %0d", err_pc, err_store, err_halt);
    if (timed_out || err_pc + err_store + err_halt != 0) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/rv_core.sv
// --------------------------------------------------------------------------
// single-cycle rv32 core: pc, branch resolution, write-back, memory ports
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::word_t    i_insn,
  output rv_core_pkg::word_t    o_pc,
  output rv_core_pkg::word_t    o_dmem_addr,
  output rv_core_pkg::word_t    o_dmem_wdata,
  output rv_core_pkg::byte_en_t o_dmem_be,
  output logic                  o_halt
);
  import rv_core_pkg::*;

  word_t     pc, pc_next, pc_plus4, pc_rel_target, jalr_target, jump_target;
  word_t     imm, rs1_data, rs2_data, alu_b, alu_result, upper_value, wb_data;
  reg_addr_t rs1, rs2, rd;
  alu_op_t   alu_op;
  logic [2:0] br_funct;
  logic      use_imm, rd_we, is_branch, is_jal, is_jalr, is_store, is_auipc, is_lui;
  logic      dec_halt, alu_eq, alu_lt, alu_ltu;
  logic      br_cond, take, target_ok, bad_jump, store_ok;

  rv_decoder u_decoder (
    .i_insn      (i_insn),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_use_imm   (use_imm),
    .o_rd_we     (rd_we),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_is_store  (is_store),
    .o_is_auipc  (is_auipc),
    .o_is_lui    (is_lui),
    .o_halt      (dec_halt),
    .o_alu_op    (alu_op),
    .o_br_funct  (br_funct)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rd_we && !bad_jump),
    .i_rd_data  (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .o_result (alu_result),
    .o_eq     (alu_eq),
    .o_lt     (alu_lt),
    .o_ltu    (alu_ltu)
  );

  always_comb begin
    case (br_funct)
      3'b000:  br_cond = alu_eq;
      3'b001:  br_cond = !alu_eq;
      3'b100:  br_cond = alu_lt;
      3'b101:  br_cond = !alu_lt;
      3'b110:  br_cond = alu_ltu;
      default: br_cond = !alu_ltu;
    endcase
  end

  assign pc_plus4      = pc + 32'd4;
  assign pc_rel_target = pc + imm;
  assign jalr_target   = {alu_result[`RV_XLEN-1:1], 1'b0};
  assign jump_target   = is_jalr ? jalr_target : pc_rel_target;
  assign target_ok     = (jump_target[1:0] == 2'b00);
  assign take          = is_jal || is_jalr || (is_branch && br_cond);
  // misaligned jumps drop the link write as well
  assign bad_jump      = (is_jal || is_jalr) && !target_ok;

  always_comb begin
    if (dec_halt) begin
      pc_next = pc;
    end else if (take && target_ok) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // lui and auipc share one adder
  assign upper_value = imm + (is_auipc ? pc : '0);
  assign wb_data = (is_jal || is_jalr)  ? pc_plus4 :
                   (is_lui || is_auipc) ? upper_value : alu_result;

  // sw address is rs1 + imm from the alu
  assign store_ok     = is_store && (alu_result[1:0] == 2'b00);
  assign o_dmem_be    = store_ok ? '1 : '0;
  assign o_dmem_addr  = store_ok ? alu_result : '0;
  assign o_dmem_wdata = store_ok ? rs2_data : '0;

  assign o_pc   = pc;
  assign o_halt = dec_halt;

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
// --------------------------------------------------------------------------
// register file, two read ports and one write port, x0 hardwired
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_core_pkg::reg_addr_t i_rs1,
  input  rv_core_pkg::reg_addr_t i_rs2,
  input  rv_core_pkg::reg_addr_t i_rd,
  input  logic                   i_we,
  input  rv_core_pkg::word_t     i_rd_data,
  output rv_core_pkg::word_t     o_rs1_data,
  output rv_core_pkg::word_t     o_rs2_data
);
  import rv_core_pkg::*;

  // no storage behind x0
  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: design/rv_alu.sv
// --------------------------------------------------------------------------
// alu with compare flags for branch resolution
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_core_pkg::word_t   i_a,
  input  rv_core_pkg::word_t   i_b,
  input  rv_core_pkg::alu_op_t i_op,
  output rv_core_pkg::word_t   o_result,
  output logic                 o_eq,
  output logic                 o_lt,
  output logic                 o_ltu
);
  import rv_core_pkg::*;

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  // flags are valid for any op
  assign o_eq  = (i_a == i_b);
  assign o_lt  = ($signed(i_a) < $signed(i_b));
  assign o_ltu = (i_a < i_b);

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SLT:    o_result = word_t'(o_lt);
      ALU_SLTU:   o_result = word_t'(o_ltu);
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_SRA:    o_result = $signed(i_a) >>> shamt;
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
// --------------------------------------------------------------------------
// instruction decoder: field split, immediates, per-cycle control
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_core_pkg::word_t     i_insn,
  output rv_core_pkg::reg_addr_t o_rs1,
  output rv_core_pkg::reg_addr_t o_rs2,
  output rv_core_pkg::reg_addr_t o_rd,
  output rv_core_pkg::word_t     o_imm,
  output logic                   o_use_imm,
  output logic                   o_rd_we,
  output logic                   o_is_branch,
  output logic                   o_is_jal,
  output logic                   o_is_jalr,
  output logic                   o_is_store,
  output logic                   o_is_auipc,
  output logic                   o_is_lui,
  output logic                   o_halt,
  output rv_core_pkg::alu_op_t   o_alu_op,
  output rv_isa_pkg::funct3_t    o_br_funct
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i, imm_s, imm_b, imm_j, imm_u;
  alu_op_t arith_op;
  logic    reg_form, alt_ok, f7_checked, arith_legal;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];
  assign o_br_funct = funct3;

  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  // shared by op-imm and op-reg
  assign reg_form = (opcode == OP_REG);
  always_comb begin
    alt_ok = 1'b0;
    case (funct3)
      3'b000: begin
        arith_op = (reg_form && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        alt_ok   = reg_form;
      end
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: begin
        arith_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        alt_ok   = 1'b1;
      end
      3'b110: arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // immediate forms only constrain funct7 on shifts
  assign f7_checked  = reg_form || (funct3[1:0] == 2'b01);
  assign arith_legal = !f7_checked || (funct7 == F7_BASE) || (alt_ok && funct7 == F7_ALT);

  always_comb begin
    o_imm       = '0;
    o_use_imm   = 1'b0;
    o_rd_we     = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_is_store  = 1'b0;
    o_is_auipc  = 1'b0;
    o_is_lui    = 1'b0;
    o_halt      = 1'b0;
    o_alu_op    = ALU_ADD;
    case (opcode)
      OP_LUI: begin
        o_rd_we   = 1'b1;
        o_is_lui  = 1'b1;
        o_imm     = imm_u;
        o_use_imm = 1'b1;
        o_alu_op  = ALU_PASS_B;
      end
      OP_AUIPC: begin
        o_rd_we    = 1'b1;
        o_is_auipc = 1'b1;
        o_imm      = imm_u;
      end
      OP_JAL: begin
        o_rd_we  = 1'b1;
        o_is_jal = 1'b1;
        o_imm    = imm_j;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          o_rd_we   = 1'b1;
          o_is_jalr = 1'b1;
          o_imm     = imm_i;
          o_use_imm = 1'b1;
        end
      end
      OP_BRANCH: begin
        // 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          o_is_branch = 1'b1;
          o_imm       = imm_b;
          o_alu_op    = ALU_SUB;
        end
      end
      OP_STORE: begin
        // sw only, address comes out of the alu
        if (funct3 == 3'b010) begin
          o_is_store = 1'b1;
          o_imm      = imm_s;
          o_use_imm  = 1'b1;
        end
      end
      OP_IMM: begin
        if (arith_legal) begin
          o_rd_we   = 1'b1;
          o_imm     = imm_i;
          o_use_imm = 1'b1;
          o_alu_op  = arith_op;
        end
      end
      OP_REG: begin
        if (arith_legal) begin
          o_rd_we  = 1'b1;
          o_alu_op = arith_op;
        end
      end
      OP_SYSTEM: begin
        // ecall only
        o_halt = (i_insn[31:7] == '0);
      end
      OP_MISC_MEM: begin
        // fence, nothing to order in this core
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_core_pkg.sv
// --------------------------------------------------------------------------
// datapath types and alu operation codes
// --------------------------------------------------------------------------
`default_nettype none

`include "rv_settings.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;
  typedef logic [3:0]            byte_en_t;
  typedef logic [3:0]            alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
// --------------------------------------------------------------------------
// rv32i encoding: opcode and funct field types with their named values
// --------------------------------------------------------------------------
`default_nettype none

package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_IMM      = 7'b0010011;
  localparam opcode_t OP_REG      = 7'b0110011;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;

  // funct7 selects sub and sra
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// File: design/rv_settings.svh
// --------------------------------------------------------------------------
// core size macros: word width, register file size, reset pc
// --------------------------------------------------------------------------
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN 32
`define RV_NUM_REGS 32
`define RV_REG_AW 5
`define RV_RESET_PC 32'h0000_0000

`endif
